//--- hdl/soc_map_pkg.sv
`default_nettype none

package soc_map_pkg;

    // External RAM, decoded by the top nibble
    localparam logic [31:0] RAM_BASE   = 32'h4000_0000;
    localparam logic [31:0] RAM_MASK   = 32'h0FFF_FFFF;

    // Timer block, forwarded to iomem as well
    localparam logic [31:0] TIMER_BASE = 32'h3000_0000;
    localparam logic [31:0] TIMER_MASK = 32'h0000_00FF;

    // On-chip peripherals, 16 bytes each
    localparam logic [31:0] SPI_BASE   = 32'h2000_0000;
    localparam logic [31:0] SPI_MASK   = 32'h0000_000F;
    localparam logic [31:0] UART_BASE  = 32'h2000_0010;
    localparam logic [31:0] UART_MASK  = 32'h0000_000F;

    typedef enum logic [2:0] {
        REGION_NONE,
        REGION_RAM,
        REGION_TIMER,
        REGION_SPI,
        REGION_UART
    } region_e;

endpackage

`default_nettype wire

//--- hdl/bus_pkg.sv
`default_nettype none

package bus_pkg;

    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;
    localparam int STRB_W   = 4;
    localparam int OFFSET_W = 4;

    // Register offsets inside a peripheral
    localparam logic [OFFSET_W-1:0] REG_DATA   = 4'h0;
    localparam logic [OFFSET_W-1:0] REG_STATUS = 4'h4;

    // SPI clock, cycles per SCK half period
    localparam int SPI_HALF_PERIOD = 2;
    localparam int SPI_CNT_W       = $clog2(SPI_HALF_PERIOD + 1);
    localparam logic [SPI_CNT_W-1:0] SPI_CNT_MAX = SPI_CNT_W'(SPI_HALF_PERIOD - 1);

    // UART bit time in clock cycles
    localparam int UART_BIT_CYCLES = 8;
    localparam int UART_CNT_W      = $clog2(UART_BIT_CYCLES + 1);
    localparam logic [UART_CNT_W-1:0] UART_CNT_MAX  = UART_CNT_W'(UART_BIT_CYCLES - 1);
    localparam logic [UART_CNT_W-1:0] UART_CNT_HALF = UART_CNT_W'(UART_BIT_CYCLES / 2 - 1);

    typedef enum logic [1:0] {
        SPI_IDLE,
        SPI_SHIFT,
        SPI_DONE
    } spi_state_e;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } uart_tx_state_e;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } uart_rx_state_e;

endpackage

`default_nettype wire

//--- hdl/periph_bus_if.sv
`default_nettype none

interface periph_bus_if
    import bus_pkg::*;
();

    // Request, held stable while valid is high
    logic                valid;
    logic                write;
    logic [OFFSET_W-1:0] offset;
    logic [DATA_W-1:0]   wdata;
    logic                ready;

    // Read data, one cycle after accept
    logic [DATA_W-1:0]   rdata;
    logic                rvalid;

    modport ctrl (
        output valid, write, offset, wdata,
        input  ready, rdata, rvalid
    );

    modport periph (
        input  valid, write, offset, wdata,
        output ready, rdata, rvalid
    );

endinterface

`default_nettype wire

//--- hdl/bus_controller.sv
`default_nettype none

module bus_controller
    import bus_pkg::*;
    import soc_map_pkg::*;
(
    input  wire                clk,
    input  wire                resetn,

    input  wire                req_valid_i,
    input  wire                req_write_i,
    input  wire  [ADDR_W-1:0]  req_addr_i,
    input  wire  [DATA_W-1:0]  req_wdata_i,
    output logic               req_ready_o,
    output logic               rsp_valid_o,
    output logic [DATA_W-1:0]  rsp_data_o,

    output logic               iomem_valid_o,
    output logic [STRB_W-1:0]  iomem_wstrb_o,
    output logic [ADDR_W-1:0]  iomem_addr_o,
    output logic [DATA_W-1:0]  iomem_wdata_o,
    input  wire                iomem_ready_i,
    input  wire  [DATA_W-1:0]  iomem_rdata_i,

    periph_bus_if.ctrl         spi_bus,
    periph_bus_if.ctrl         uart_bus
);

    region_e             region;
    logic                target_ready;
    logic                mem_rd_pend;
    logic [DATA_W-1:0]   mem_rdata_q;

    always_comb begin
        if ((req_addr_i & ~RAM_MASK) == RAM_BASE) begin
            region = REGION_RAM;
        end else if ((req_addr_i & ~TIMER_MASK) == TIMER_BASE) begin
            region = REGION_TIMER;
        end else if ((req_addr_i & ~SPI_MASK) == SPI_BASE) begin
            region = REGION_SPI;
        end else if ((req_addr_i & ~UART_MASK) == UART_BASE) begin
            region = REGION_UART;
        end else begin
            region = REGION_NONE;
        end
    end

    // RAM and timer both live behind iomem
    assign iomem_valid_o = req_valid_i && (region == REGION_RAM || region == REGION_TIMER);
    assign iomem_wstrb_o = {STRB_W{req_write_i}};
    assign iomem_addr_o  = req_addr_i;
    assign iomem_wdata_o = req_wdata_i;

    assign spi_bus.valid  = req_valid_i && (region == REGION_SPI);
    assign spi_bus.write  = req_write_i;
    assign spi_bus.offset = req_addr_i[OFFSET_W-1:0];
    assign spi_bus.wdata  = req_wdata_i;

    assign uart_bus.valid  = req_valid_i && (region == REGION_UART);
    assign uart_bus.write  = req_write_i;
    assign uart_bus.offset = req_addr_i[OFFSET_W-1:0];
    assign uart_bus.wdata  = req_wdata_i;

    // Unmapped addresses never see ready
    always_comb begin
        case (region)
            REGION_RAM, REGION_TIMER: target_ready = iomem_ready_i;
            REGION_SPI:               target_ready = spi_bus.ready;
            REGION_UART:              target_ready = uart_bus.ready;
            default:                  target_ready = 1'b0;
        endcase
    end

    assign req_ready_o = req_valid_i && target_ready;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem_rd_pend <= 1'b0;
        end else begin
            mem_rd_pend <= iomem_valid_o && iomem_ready_i && !req_write_i;
        end
    end

    always_ff @(posedge clk) begin
        if (iomem_valid_o && iomem_ready_i) begin
            mem_rdata_q <= iomem_rdata_i;
        end
    end

    // Memory first, then SPI, then UART
    assign rsp_valid_o = mem_rd_pend || spi_bus.rvalid || uart_bus.rvalid;

    always_comb begin
        if (mem_rd_pend) begin
            rsp_data_o = mem_rdata_q;
        end else if (spi_bus.rvalid) begin
            rsp_data_o = spi_bus.rdata;
        end else if (uart_bus.rvalid) begin
            rsp_data_o = uart_bus.rdata;
        end else begin
            rsp_data_o = '0;
        end
    end

    assert property (@(posedge clk) disable iff (!resetn)
        $onehot0({iomem_valid_o, spi_bus.valid, uart_bus.valid}));

    assert property (@(posedge clk) disable iff (!resetn)
        req_ready_o |-> req_valid_i);

endmodule

`default_nettype wire

//--- hdl/spi_master.sv
`default_nettype none

module spi_master
    import bus_pkg::*;
(
    input  wire           clk,
    input  wire           resetn,
    periph_bus_if.periph  bus,
    output logic          spi_cs_o,
    output logic          spi_sck_o,
    output logic          spi_mosi_o,
    input  wire           spi_miso_i
);

    spi_state_e            state;
    logic [SPI_CNT_W-1:0]  half_cnt;
    logic [2:0]            bit_cnt;
    logic [7:0]            shreg;
    logic [7:0]            rx_data;
    logic                  miso_q;
    logic                  busy;
    logic                  start;
    logic                  edge_tick;

    assign busy      = (state != SPI_IDLE);
    assign bus.ready = !(bus.write && bus.offset == REG_DATA) || !busy;
    assign start     = bus.valid && bus.ready && bus.write && (bus.offset == REG_DATA);
    assign edge_tick = (half_cnt == SPI_CNT_MAX);

    // MSB first, shifted on the falling SCK edge
    assign spi_mosi_o = shreg[7];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state     <= SPI_IDLE;
            spi_cs_o  <= 1'b1;
            spi_sck_o <= 1'b0;
            half_cnt  <= '0;
            bit_cnt   <= '0;
        end else begin
            case (state)
                SPI_IDLE: begin
                    if (start) begin
                        state    <= SPI_SHIFT;
                        spi_cs_o <= 1'b0;
                        half_cnt <= '0;
                        bit_cnt  <= '0;
                    end
                end
                SPI_SHIFT: begin
                    half_cnt <= edge_tick ? '0 : half_cnt + 1'b1;
                    if (edge_tick) begin
                        spi_sck_o <= !spi_sck_o;
                        if (spi_sck_o) begin
                            bit_cnt <= bit_cnt + 3'd1;
                            if (bit_cnt == 3'd7) begin
                                state <= SPI_DONE;
                            end
                        end
                    end
                end
                SPI_DONE: begin
                    state    <= SPI_IDLE;
                    spi_cs_o <= 1'b1;
                end
                default: state <= SPI_IDLE;
            endcase
        end
    end

    // MISO caught on the rise, pushed in on the fall
    always_ff @(posedge clk) begin
        if (start) begin
            shreg <= bus.wdata[7:0];
        end else if (state == SPI_SHIFT && edge_tick) begin
            if (!spi_sck_o) begin
                miso_q <= spi_miso_i;
            end else begin
                shreg <= {shreg[6:0], miso_q};
            end
        end
        if (state == SPI_DONE) begin
            rx_data <= shreg;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            bus.rvalid <= 1'b0;
        end else begin
            bus.rvalid <= bus.valid && bus.ready && !bus.write;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.valid && !bus.write) begin
            case (bus.offset)
                REG_DATA:   bus.rdata <= {{(DATA_W-8){1'b0}}, rx_data};
                REG_STATUS: bus.rdata <= {{(DATA_W-1){1'b0}}, busy};
                default:    bus.rdata <= '0;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!resetn)
        (state == SPI_IDLE) |-> spi_cs_o);

endmodule

`default_nettype wire

//--- hdl/uart_port.sv
`default_nettype none

module uart_port
    import bus_pkg::*;
(
    input  wire           clk,
    input  wire           resetn,
    periph_bus_if.periph  bus,
    output logic          uart_tx_o,
    input  wire           uart_rx_i
);

    uart_tx_state_e         tx_state;
    uart_rx_state_e         rx_state;
    logic [UART_CNT_W-1:0]  tx_cnt;
    logic [UART_CNT_W-1:0]  rx_cnt;
    logic [2:0]             tx_bit;
    logic [2:0]             rx_bit;
    logic [7:0]             tx_data;
    logic [7:0]             rx_shift;
    logic [7:0]             rx_hold;
    logic                   rx_valid;
    logic                   rx_s1;
    logic                   rx_s2;
    logic                   tx_busy;
    logic                   tx_start;
    logic                   tx_tick;
    logic                   rx_tick;
    logic                   rx_done;
    logic                   rd_data;

    assign tx_busy   = (tx_state != TX_IDLE);
    assign bus.ready = !(bus.write && bus.offset == REG_DATA) || !tx_busy;
    assign tx_start  = bus.valid && bus.ready && bus.write && (bus.offset == REG_DATA);
    assign rd_data   = bus.valid && bus.ready && !bus.write && (bus.offset == REG_DATA);
    assign tx_tick   = (tx_cnt == UART_CNT_MAX);
    assign rx_tick   = (rx_cnt == UART_CNT_MAX);
    assign rx_done   = (rx_state == RX_STOP) && rx_tick && rx_s2;

    // 8N1 transmitter, LSB first
    always_ff @(posedge clk) begin
        if (!resetn) begin
            tx_state  <= TX_IDLE;
            uart_tx_o <= 1'b1;
            tx_cnt    <= '0;
            tx_bit    <= '0;
        end else begin
            if (tx_busy) begin
                tx_cnt <= tx_tick ? '0 : tx_cnt + 1'b1;
            end
            case (tx_state)
                TX_IDLE: begin
                    if (tx_start) begin
                        tx_state  <= TX_START;
                        uart_tx_o <= 1'b0;
                        tx_cnt    <= '0;
                        tx_bit    <= '0;
                    end
                end
                TX_START: begin
                    if (tx_tick) begin
                        tx_state  <= TX_DATA;
                        uart_tx_o <= tx_data[0];
                    end
                end
                TX_DATA: begin
                    if (tx_tick) begin
                        tx_bit <= tx_bit + 3'd1;
                        if (tx_bit == 3'd7) begin
                            tx_state  <= TX_STOP;
                            uart_tx_o <= 1'b1;
                        end else begin
                            uart_tx_o <= tx_data[tx_bit + 3'd1];
                        end
                    end
                end
                TX_STOP: begin
                    if (tx_tick) begin
                        tx_state <= TX_IDLE;
                    end
                end
                default: tx_state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (tx_start) begin
            tx_data <= bus.wdata[7:0];
        end
    end

    // Receiver samples each bit in its middle
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rx_s1    <= 1'b1;
            rx_s2    <= 1'b1;
            rx_state <= RX_IDLE;
            rx_cnt   <= '0;
            rx_bit   <= '0;
        end else begin
            rx_s1 <= uart_rx_i;
            rx_s2 <= rx_s1;
            case (rx_state)
                RX_IDLE: begin
                    if (!rx_s2) begin
                        rx_state <= RX_START;
                        rx_cnt   <= '0;
                    end
                end
                RX_START: begin
                    if (rx_cnt == UART_CNT_HALF) begin
                        rx_cnt   <= '0;
                        rx_bit   <= '0;
                        // Glitch shorter than half a bit
                        rx_state <= rx_s2 ? RX_IDLE : RX_DATA;
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    rx_cnt <= rx_tick ? '0 : rx_cnt + 1'b1;
                    if (rx_tick) begin
                        rx_bit <= rx_bit + 3'd1;
                        if (rx_bit == 3'd7) begin
                            rx_state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    rx_cnt <= rx_tick ? '0 : rx_cnt + 1'b1;
                    if (rx_tick) begin
                        rx_state <= RX_IDLE;
                    end
                end
                default: rx_state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rx_state == RX_DATA && rx_tick) begin
            rx_shift <= {rx_s2, rx_shift[7:1]};
        end
        if (rx_done) begin
            rx_hold <= rx_shift;
        end
    end

    // New byte wins over a read in the same cycle
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rx_valid <= 1'b0;
        end else if (rx_done) begin
            rx_valid <= 1'b1;
        end else if (rd_data) begin
            rx_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            bus.rvalid <= 1'b0;
        end else begin
            bus.rvalid <= bus.valid && bus.ready && !bus.write;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.valid && !bus.write) begin
            case (bus.offset)
                REG_DATA:   bus.rdata <= {{(DATA_W-8){1'b0}}, rx_hold};
                REG_STATUS: bus.rdata <= {{(DATA_W-2){1'b0}}, rx_valid, tx_busy};
                default:    bus.rdata <= '0;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!resetn)
        (tx_state == TX_IDLE) |-> uart_tx_o);

endmodule

`default_nettype wire

//--- hdl/io_subsystem.sv
`default_nettype none

module io_subsystem
    import bus_pkg::*;
(
    input  wire               clk,
    input  wire               resetn,

    input  wire               req_valid_i,
    input  wire               req_write_i,
    input  wire  [ADDR_W-1:0] req_addr_i,
    input  wire  [DATA_W-1:0] req_wdata_i,
    output wire               req_ready_o,
    output wire               rsp_valid_o,
    output wire  [DATA_W-1:0] rsp_data_o,

    output wire               iomem_valid_o,
    output wire  [STRB_W-1:0] iomem_wstrb_o,
    output wire  [ADDR_W-1:0] iomem_addr_o,
    output wire  [DATA_W-1:0] iomem_wdata_o,
    input  wire               iomem_ready_i,
    input  wire  [DATA_W-1:0] iomem_rdata_i,

    output wire               spi_cs_o,
    output wire               spi_sck_o,
    output wire               spi_mosi_o,
    input  wire               spi_miso_i,

    output wire               uart_tx_o,
    input  wire               uart_rx_i
);

    periph_bus_if spi_bus ();
    periph_bus_if uart_bus ();

    bus_controller u_bus_controller (
        .clk            ( clk ),
        .resetn         ( resetn ),
        .req_valid_i    ( req_valid_i ),
        .req_write_i    ( req_write_i ),
        .req_addr_i     ( req_addr_i ),
        .req_wdata_i    ( req_wdata_i ),
        .req_ready_o    ( req_ready_o ),
        .rsp_valid_o    ( rsp_valid_o ),
        .rsp_data_o     ( rsp_data_o ),
        .iomem_valid_o  ( iomem_valid_o ),
        .iomem_wstrb_o  ( iomem_wstrb_o ),
        .iomem_addr_o   ( iomem_addr_o ),
        .iomem_wdata_o  ( iomem_wdata_o ),
        .iomem_ready_i  ( iomem_ready_i ),
        .iomem_rdata_i  ( iomem_rdata_i ),
        .spi_bus        ( spi_bus.ctrl ),
        .uart_bus       ( uart_bus.ctrl )
    );

    spi_master u_spi_master (
        .clk            ( clk ),
        .resetn         ( resetn ),
        .bus            ( spi_bus.periph ),
        .spi_cs_o       ( spi_cs_o ),
        .spi_sck_o      ( spi_sck_o ),
        .spi_mosi_o     ( spi_mosi_o ),
        .spi_miso_i     ( spi_miso_i )
    );

    uart_port u_uart_port (
        .clk            ( clk ),
        .resetn         ( resetn ),
        .bus            ( uart_bus.periph ),
        .uart_tx_o      ( uart_tx_o ),
        .uart_rx_i      ( uart_rx_i )
    );

endmodule

`default_nettype wire

//--- testbench/io_subsystem_tb.sv
`default_nettype none

module io_subsystem_tb
    import bus_pkg::*;
    import soc_map_pkg::*;
();

    localparam int RAM_WORDS    = 8;
    localparam int UART_BYTES   = 1;
    localparam int MEM_ACCESSES = 2 * RAM_WORDS + 2;
    localparam int SPI_ACCESSES = 6;
    localparam int CYCLE_LIMIT  = UART_BYTES * 12 * UART_BIT_CYCLES
                                + 40 * (MEM_ACCESSES + SPI_ACCESSES) + 200;

    // Write accept to status busy clear
    localparam int SPI_XFER_CYCLES = 16 * SPI_HALF_PERIOD + 2;

    localparam logic [31:0] SPI_DATA_ADDR    = SPI_BASE | {28'h0, REG_DATA};
    localparam logic [31:0] SPI_STATUS_ADDR  = SPI_BASE | {28'h0, REG_STATUS};
    localparam logic [31:0] UART_DATA_ADDR   = UART_BASE | {28'h0, REG_DATA};
    localparam logic [31:0] UART_STATUS_ADDR = UART_BASE | {28'h0, REG_STATUS};

    logic        clk;
    logic        resetn;
    logic        req_valid_i;
    logic        req_write_i;
    logic [31:0] req_addr_i;
    logic [31:0] req_wdata_i;
    logic        iomem_ready_i;
    logic [31:0] iomem_rdata_i;
    wire         req_ready_o;
    wire         rsp_valid_o;
    wire  [31:0] rsp_data_o;
    wire         iomem_valid_o;
    wire  [3:0]  iomem_wstrb_o;
    wire  [31:0] iomem_addr_o;
    wire  [31:0] iomem_wdata_o;
    wire         spi_cs_o;
    wire         spi_sck_o;
    wire         spi_mosi_o;
    wire         uart_tx_o;

    logic [31:0] rng_state = 32'h522a;
    logic [31:0] mem [logic [31:0]];
    logic [31:0] exp_rdata = '0;
    logic [31:0] exp_mask = '0;
    logic [7:0]  spi_tx_byte = '0;
    logic [2:0]  spi_rise_cnt = '0;
    logic        sck_prev = 1'b0;
    logic        rd_acc_q = 1'b0;
    int          spi_busy_left = 0;
    int          errors = 0;
    int          tests_run = 0;
    int          cycle_count;

    // Both loopbacks are plain wires
    io_subsystem UUT (
        .clk           ( clk ),
        .resetn        ( resetn ),
        .req_valid_i   ( req_valid_i ),
        .req_write_i   ( req_write_i ),
        .req_addr_i    ( req_addr_i ),
        .req_wdata_i   ( req_wdata_i ),
        .req_ready_o   ( req_ready_o ),
        .rsp_valid_o   ( rsp_valid_o ),
        .rsp_data_o    ( rsp_data_o ),
        .iomem_valid_o ( iomem_valid_o ),
        .iomem_wstrb_o ( iomem_wstrb_o ),
        .iomem_addr_o  ( iomem_addr_o ),
        .iomem_wdata_o ( iomem_wdata_o ),
        .iomem_ready_i ( iomem_ready_i ),
        .iomem_rdata_i ( iomem_rdata_i ),
        .spi_cs_o      ( spi_cs_o ),
        .spi_sck_o     ( spi_sck_o ),
        .spi_mosi_o    ( spi_mosi_o ),
        .spi_miso_i    ( spi_mosi_o ),
        .uart_tx_o     ( uart_tx_o ),
        .uart_rx_i     ( uart_tx_o )
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5A5A_C3C3;
    endfunction

    function automatic logic maps_to_iomem(input logic [31:0] addr);
        return ((addr & ~RAM_MASK) == RAM_BASE) || ((addr & ~TIMER_MASK) == TIMER_BASE);
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("[FAIL] %s expected %h actual %h", name, expected, actual);
    endtask

    // Decides at the rising edge and drives at the falling edge
    initial begin : memory_model
        int          wait_left;
        logic        armed;
        logic        ready_next;
        logic [31:0] rdata_next;
        armed = 1'b0;
        wait_left = 0;
        iomem_ready_i = 1'b0;
        iomem_rdata_i = '0;
        forever begin
            @(posedge clk);
            ready_next = 1'b0;
            rdata_next = '0;
            if (iomem_valid_o && iomem_ready_i) begin
                if (iomem_wstrb_o != 4'h0) begin
                    mem[iomem_addr_o] = iomem_wdata_o;
                end
                armed = 1'b0;
            end else if (iomem_valid_o) begin
                if (!armed) begin
                    wait_left = int'(next_random() & 32'h3);
                    armed = 1'b1;
                end
                if (wait_left == 0) begin
                    ready_next = 1'b1;
                    rdata_next = mem.exists(iomem_addr_o) ? mem[iomem_addr_o]
                                                          : fill_word(iomem_addr_o);
                end else begin
                    wait_left--;
                end
            end
            @(negedge clk);
            iomem_ready_i = ready_next;
            iomem_rdata_i = rdata_next;
        end
    end

    // SCK rises seen so far in the current byte
    always @(posedge clk) begin
        if (spi_cs_o) begin
            spi_rise_cnt <= '0;
        end else if (spi_sck_o && !sck_prev) begin
            spi_rise_cnt <= spi_rise_cnt + 3'd1;
        end
        sck_prev <= spi_sck_o;
        rd_acc_q <= req_valid_i && req_ready_o && !req_write_i;
        // Cycles left until the SPI master is idle again
        if (req_valid_i && req_ready_o && req_write_i && req_addr_i == SPI_DATA_ADDR) begin
            spi_busy_left <= SPI_XFER_CYCLES - 1;
        end else if (spi_busy_left != 0) begin
            spi_busy_left <= spi_busy_left - 1;
        end
    end

    assert property (@(posedge clk) $rose(resetn) |-> spi_cs_o)
        else report_mismatch("spi_cs_o", 32'h1, 32'($sampled(spi_cs_o)));
    assert property (@(posedge clk) $rose(resetn) |-> !spi_sck_o)
        else report_mismatch("spi_sck_o", 32'h0, 32'($sampled(spi_sck_o)));
    assert property (@(posedge clk) $rose(resetn) |-> uart_tx_o)
        else report_mismatch("uart_tx_o", 32'h1, 32'($sampled(uart_tx_o)));
    assert property (@(posedge clk) $rose(resetn) |-> !iomem_valid_o)
        else report_mismatch("iomem_valid_o", 32'h0, 32'($sampled(iomem_valid_o)));

    // One response exactly one cycle after each read accept and none after writes
    assert property (@(posedge clk) disable iff (!resetn) rsp_valid_o == rd_acc_q)
        else report_mismatch("rsp_valid_o", 32'($sampled(rd_acc_q)),
                             32'($sampled(rsp_valid_o)));
    assert property (@(posedge clk) disable iff (!resetn)
        (rsp_valid_o && exp_mask != 0) |-> ((rsp_data_o & exp_mask) == exp_rdata))
        else report_mismatch("rsp_data_o", $sampled(exp_rdata),
                             $sampled(rsp_data_o) & $sampled(exp_mask));

    assert property (@(posedge clk) disable iff (!resetn)
        iomem_valid_o |-> (iomem_wstrb_o == (req_write_i ? 4'hF : 4'h0)))
        else report_mismatch("iomem_wstrb_o", $sampled(req_write_i) ? 32'hF : 32'h0,
                             32'($sampled(iomem_wstrb_o)));
    assert property (@(posedge clk) disable iff (!resetn)
        iomem_valid_o |-> (iomem_addr_o == req_addr_i))
        else report_mismatch("iomem_addr_o", $sampled(req_addr_i), $sampled(iomem_addr_o));
    assert property (@(posedge clk) disable iff (!resetn)
        (iomem_valid_o && req_write_i) |-> (iomem_wdata_o == req_wdata_i))
        else report_mismatch("iomem_wdata_o", $sampled(req_wdata_i),
                             $sampled(iomem_wdata_o));
    assert property (@(posedge clk) disable iff (!resetn)
        req_valid_i |-> (iomem_valid_o == maps_to_iomem(req_addr_i)))
        else report_mismatch("iomem_valid_o", 32'(maps_to_iomem($sampled(req_addr_i))),
                             32'($sampled(iomem_valid_o)));

    assert property (@(posedge clk) disable iff (!resetn)
        $rose(spi_sck_o) |-> (spi_mosi_o == spi_tx_byte[3'd7 - spi_rise_cnt]))
        else report_mismatch("spi_mosi_o",
                             32'($sampled(spi_tx_byte[3'd7 - spi_rise_cnt])),
                             32'($sampled(spi_mosi_o)));
    assert property (@(posedge clk) disable iff (!resetn) $rose(spi_sck_o) |-> !spi_cs_o)
        else report_mismatch("spi_cs_o", 32'h0, 32'($sampled(spi_cs_o)));
    // Data writes wait for the whole transfer and no longer
    assert property (@(posedge clk) disable iff (!resetn)
        (req_valid_i && req_write_i && req_addr_i == SPI_DATA_ADDR)
        |-> (req_ready_o == (spi_busy_left == 0)))
        else report_mismatch("req_ready_o", 32'($sampled(spi_busy_left) == 0),
                             32'($sampled(req_ready_o)));

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Something failed");
        $finish;
    end

    // Starts and ends at a falling edge
    task automatic bus_access(input logic wr, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        logic accepted;
        accepted = 1'b0;
        rdata = '0;
        req_valid_i = 1'b1;
        req_write_i = wr;
        req_addr_i = addr;
        req_wdata_i = wdata;
        while (!accepted) begin
            @(posedge clk);
            accepted = req_ready_o;
        end
        @(negedge clk);
        req_valid_i = 1'b0;
        req_write_i = 1'b0;
        if (!wr) begin
            @(posedge clk);
            rdata = rsp_data_o;
            @(negedge clk);
        end
    endtask

    task automatic end_test(input int num, input string name, input int errs_before);
        tests_run++;
        $display("test %0d %s: %0d failures", num, name, errors - errs_before);
    endtask

    initial begin : stimulus
        logic [31:0] rdata;
        logic [31:0] rnd;
        logic [31:0] addr;
        logic [31:0] addr_list [$];
        logic [31:0] ram_ref [logic [31:0]];
        logic [7:0]  byte_a;
        logic [7:0]  byte_b;
        int          errs_before;
        resetn = 1'b0;
        req_valid_i = 1'b0;
        req_write_i = 1'b0;
        req_addr_i = '0;
        req_wdata_i = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        errs_before = errors;
        @(posedge clk);
        @(negedge clk);
        end_test(1, "reset state", errs_before);

        errs_before = errors;
        for (int i = 0; i < RAM_WORDS; i++) begin
            rnd = next_random();
            addr = RAM_BASE | (rnd & RAM_MASK & 32'hFFFF_FFFC);
            rnd = next_random();
            ram_ref[addr] = rnd;
            addr_list.push_back(addr);
            bus_access(1'b1, addr, rnd, rdata);
        end
        foreach (addr_list[i]) begin
            exp_rdata = ram_ref[addr_list[i]];
            exp_mask = '1;
            bus_access(1'b0, addr_list[i], 32'h0, rdata);
        end
        end_test(2, "ram write and read", errs_before);

        errs_before = errors;
        rnd = next_random();
        addr = TIMER_BASE | (rnd & TIMER_MASK & 32'hFFFF_FFFC);
        rnd = next_random();
        bus_access(1'b1, addr, rnd, rdata);
        exp_rdata = rnd;
        exp_mask = '1;
        bus_access(1'b0, addr, 32'h0, rdata);
        exp_mask = '0;
        bus_access(1'b0, SPI_STATUS_ADDR, 32'h0, rdata);
        bus_access(1'b0, UART_STATUS_ADDR, 32'h0, rdata);
        end_test(3, "timer and peripheral routing", errs_before);

        errs_before = errors;
        rnd = next_random();
        byte_a = rnd[7:0];
        bus_access(1'b1, SPI_DATA_ADDR, {24'h0, byte_a}, rdata);
        spi_tx_byte = byte_a;
        exp_mask = '0;
        do begin
            bus_access(1'b0, SPI_STATUS_ADDR, 32'h0, rdata);
        end while (rdata[0]);
        exp_rdata = {24'h0, byte_a};
        exp_mask = '1;
        bus_access(1'b0, SPI_DATA_ADDR, 32'h0, rdata);
        end_test(4, "spi loopback", errs_before);

        errs_before = errors;
        rnd = next_random();
        byte_a = rnd[7:0];
        byte_b = rnd[15:8];
        bus_access(1'b1, SPI_DATA_ADDR, {24'h0, byte_a}, rdata);
        spi_tx_byte = byte_a;
        // Held until the first byte is out
        bus_access(1'b1, SPI_DATA_ADDR, {24'h0, byte_b}, rdata);
        spi_tx_byte = byte_b;
        exp_mask = '0;
        do begin
            bus_access(1'b0, SPI_STATUS_ADDR, 32'h0, rdata);
        end while (rdata[0]);
        exp_rdata = {24'h0, byte_b};
        exp_mask = '1;
        bus_access(1'b0, SPI_DATA_ADDR, 32'h0, rdata);
        end_test(5, "spi write while busy", errs_before);

        errs_before = errors;
        rnd = next_random();
        byte_a = rnd[7:0];
        bus_access(1'b1, UART_DATA_ADDR, {24'h0, byte_a}, rdata);
        exp_mask = '0;
        do begin
            bus_access(1'b0, UART_STATUS_ADDR, 32'h0, rdata);
        end while (!rdata[1]);
        exp_rdata = {24'h0, byte_a};
        exp_mask = '1;
        bus_access(1'b0, UART_DATA_ADDR, 32'h0, rdata);
        exp_rdata = '0;
        exp_mask = 32'h2;
        bus_access(1'b0, UART_STATUS_ADDR, 32'h0, rdata);
        end_test(6, "uart loopback", errs_before);

        repeat (2) @(negedge clk);
        $display("tests run %0d, failed checks %0d", tests_run, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
hdl/soc_map_pkg.sv
hdl/bus_pkg.sv
hdl/periph_bus_if.sv
hdl/bus_controller.sv
hdl/spi_master.sv
hdl/uart_port.sv
hdl/io_subsystem.sv
testbench/io_subsystem_tb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert --top-module io_subsystem_tb -f list.f \
    && ./obj_dir/Vio_subsystem_tb > sim.log 2>&1 \
    || echo "Build or simulation returned an error"

grep -q "Everything OK" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
